//--- build.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/ecc_codec.sv
verilog/mem_array.sv
verilog/ecc_sram.sv
verilog/mem_arbiter.sv
verilog/mem_subsystem.sv
bench/mem_tb_sva.sv
bench/mem_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/ecc_codec.sv
      - verilog/mem_array.sv
      - verilog/ecc_sram.sv
      - verilog/mem_arbiter.sv
      - verilog/mem_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/mem_tb_sva.sv
      - bench/mem_tb.sv

//--- bench/mem_tb.sv
// Memory subsystem testbench

`default_nettype none

`include "mem_settings.svh"

module mem_tb;
  import mem_pkg::*;

  localparam int NP            = `MEM_NUM_PORTS;
  localparam int NG            = `MEM_NUM_GRANULES;
  localparam int GW            = `MEM_GRANULE_WIDTH;
  localparam int READY_TIMEOUT = 20;
  localparam int DRAIN_TIMEOUT = 20;

  typedef struct {
    int                         port;
    logic                       write;
    logic [`MEM_DATA_WIDTH-1:0] data;
    tag_t                       tag;
    ecc_err_t                   err;
  } rsp_exp_t;

  logic                                  clk_i;
  logic                                  reset_i;
  logic [NP-1:0]                         req_valid_i;
  logic [NP-1:0]                         req_ready_o;
  logic [NP-1:0]                         req_write_i;
  logic [NP-1:0][`MEM_ADDR_WIDTH-1:0]    req_addr_i;
  logic [NP-1:0][`MEM_DATA_WIDTH-1:0]    req_wdata_i;
  logic [NP-1:0][NG-1:0]                 req_be_i;
  logic [NP-1:0][`MEM_TAG_WIDTH-1:0]     req_tag_i;
  code_word_t                            fault_mask_i;
  logic [NP-1:0]                         rsp_valid_o;
  logic [`MEM_DATA_WIDTH-1:0]            rsp_rdata_o;
  tag_t                                  rsp_tag_o;
  ecc_err_t                              rsp_err_o;

  // Reference memory keyed by address, with the injected flip count per granule
  granule_t [NG-1:0]  ref_data [int];
  tag_t               ref_tag [int];
  logic [NG-1:0][1:0] ref_flips [int];

  rsp_exp_t pending [$];
  int       last_port;

  mem_subsystem dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // With two requesters the one that did not win last goes first
  function automatic logic [NP-1:0] expected_grant(input logic [NP-1:0] valid, input int last);
    if (valid == '1) begin
      return NP'(1) << (1 - last);
    end
    return valid;
  endfunction

  function automatic void apply_write(input int addr, input logic [`MEM_DATA_WIDTH-1:0] data,
                                      input logic [NG-1:0] be, input tag_t tag,
                                      input code_word_t mask);
    granule_t [NG-1:0]  word;
    logic [NG-1:0][1:0] flips;
    int                 cnt;
    word  = ref_data.exists(addr) ? ref_data[addr] : 'x;
    flips = ref_flips.exists(addr) ? ref_flips[addr] : '0;
    for (int g = 0; g < NG; g++) begin
      if (be[g]) begin
        word[g]  = data[g*GW +: GW];
        cnt      = $countones(mask[g]);
        flips[g] = (cnt > 2) ? 2'd2 : 2'(cnt);
      end
    end
    ref_data[addr]  = word;
    ref_flips[addr] = flips;
    ref_tag[addr]   = tag;
  endfunction

  // One flipped bit in a granule is corrected, two are only detected
  function automatic void exp_read(input int addr, output logic [`MEM_DATA_WIDTH-1:0] data,
                                   output tag_t tag, output ecc_err_t err);
    data = ref_data[addr];
    tag  = ref_tag[addr];
    err  = '0;
    for (int g = 0; g < NG; g++) begin
      if (ref_flips[addr][g] == 2'd1) begin
        err[0] = 1'b1;
      end else if (ref_flips[addr][g] >= 2'd2) begin
        err[1] = 1'b1;
      end
    end
  endfunction

  always @(posedge clk_i) begin : compare
    rsp_exp_t      rec;
    logic [NP-1:0] exp_ready;
    if (reset_i) begin
      last_port = NP - 1;
      pending.delete();
    end else begin
      // A response belongs to the acceptance one edge earlier
      if (pending.size() == 0) begin
        check("rsp_valid_o", rsp_valid_o, '0);
      end else begin
        rec = pending.pop_front();
        check("rsp_valid_o", rsp_valid_o, 64'(1) << rec.port);
        if (!rec.write) begin
          if (!rec.err[1]) begin
            check("rsp_rdata_o", rsp_rdata_o, rec.data);
          end
          check("rsp_tag_o", rsp_tag_o, rec.tag);
          check("rsp_err_o", rsp_err_o, rec.err);
        end
      end
      exp_ready = expected_grant(req_valid_i, last_port);
      check("req_ready_o", req_ready_o, exp_ready);
      for (int p = 0; p < NP; p++) begin
        if (req_valid_i[p] && req_ready_o[p]) begin
          rec.port  = p;
          rec.write = req_write_i[p];
          if (req_write_i[p]) begin
            apply_write(req_addr_i[p], req_wdata_i[p], req_be_i[p], req_tag_i[p],
                        fault_mask_i);
          end else begin
            exp_read(req_addr_i[p], rec.data, rec.tag, rec.err);
          end
          pending.push_back(rec);
          last_port = p;
        end
      end
    end
  end

  // Handshake assertions in the arbiter end the run like any other check
  always @(posedge clk_i) begin : assertion_watch
    if (dut.i_mem_arbiter.i_mem_tb_sva.error_count != 0) begin
      fail_run("An arbiter handshake assertion failed");
    end
  end

  // Called right after a rising edge, returns right after the accepting edge
  task automatic send(input int port, input logic write, input logic [7:0] addr,
                      input logic [31:0] data, input logic [NG-1:0] be, input tag_t tag);
    int waited;
    req_valid_i[port] <= 1'b1;
    req_write_i[port] <= write;
    req_addr_i[port]  <= addr;
    req_wdata_i[port] <= data;
    req_be_i[port]    <= be;
    req_tag_i[port]   <= tag;
    waited = 0;
    @(posedge clk_i);
    while (!req_ready_o[port]) begin
      waited++;
      if (waited > READY_TIMEOUT) begin
        fail_run($sformatf("Port %0d was never granted its request", port));
      end
      @(posedge clk_i);
    end
  endtask

  task automatic idle(input int port);
    req_valid_i[port] <= 1'b0;
  endtask

  task automatic write_with_fault(input int addr, input logic [31:0] data, input tag_t tag,
                                  input code_word_t mask);
    fault_mask_i <= mask;
    send(0, 1'b1, addr, data, 2'b11, tag);
    fault_mask_i <= '0;
    idle(0);
  endtask

  task automatic random_traffic(input int port, input int count);
    int gap;
    for (int i = 0; i < count; i++) begin
      gap = $urandom_range(0, 2);
      if (gap != 0) begin
        idle(port);
        repeat (gap) @(posedge clk_i);
      end
      send(port, 1'($urandom_range(0, 1)), 8'h40 + 8'($urandom_range(0, 7)), $urandom,
           NG'($urandom_range(0, 3)), tag_t'($urandom_range(0, 15)));
    end
    idle(port);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (pending.size() != 0) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        fail_run("Responses are still outstanding after the drain timeout");
      end
      @(posedge clk_i);
    end
  endtask

  initial begin : main
    void'($urandom(32'h6827c2f1));
    reset_i      <= 1'b1;
    req_valid_i  <= '0;
    req_write_i  <= '0;
    req_addr_i   <= '0;
    req_wdata_i  <= '0;
    req_be_i     <= '0;
    req_tag_i    <= '0;
    fault_mask_i <= '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    // Full word round trip, then a write to the low granule only
    send(0, 1'b1, 8'h10, 32'hdeadbeef, 2'b11, 4'h5);
    send(0, 1'b0, 8'h10, '0, '0, '0);
    idle(0);
    send(1, 1'b1, 8'h10, 32'h12345678, 2'b01, 4'h9);
    send(1, 1'b0, 8'h10, '0, '0, '0);
    idle(1);
    drain();

    // Both ports stay valid so grants have to alternate
    for (int i = 0; i < 8; i++) begin
      send(1, 1'b1, 8'h20 + 8'(i), $urandom, 2'b11, 4'(i));
    end
    idle(1);
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          send(0, 1'b1, 8'h20 + 8'(i), $urandom, 2'b11, 4'(i + 8));
        end
        idle(0);
      end
      begin
        for (int i = 0; i < 8; i++) begin
          send(1, 1'b0, 8'h20 + 8'(i), '0, '0, '0);
        end
        idle(1);
      end
    join
    drain();

    // Single flips in data and in the parity bit, then a double flip
    write_with_fault(8'h30, 32'hcafef00d, 4'h3, {22'h000080, 22'h000000});
    write_with_fault(8'h31, 32'h0badc0de, 4'h4, {22'h000000, 22'h000001});
    write_with_fault(8'h32, 32'h55aa33cc, 4'h6, {22'h000000, 22'h001008});
    send(0, 1'b0, 8'h30, '0, '0, '0);
    send(0, 1'b0, 8'h31, '0, '0, '0);
    send(0, 1'b0, 8'h32, '0, '0, '0);
    write_with_fault(8'h32, 32'h55aa33cc, 4'h7, '0);
    send(0, 1'b0, 8'h32, '0, '0, '0);
    idle(0);
    drain();

    // Random traffic over a small, fully written window
    for (int i = 0; i < 8; i++) begin
      send(0, 1'b1, 8'h40 + 8'(i), $urandom, 2'b11, 4'(i));
    end
    idle(0);
    fork
      random_traffic(0, 40);
      random_traffic(1, 40);
    join
    drain();

    repeat (2) @(posedge clk_i);
    if (dut.i_mem_arbiter.i_mem_tb_sva.error_count != 0) begin
      fail_run("An arbiter handshake assertion failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/mem_tb_sva.sv
// Arbiter handshake assertions

`default_nettype none

`include "mem_settings.svh"

module mem_tb_sva (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic [`MEM_NUM_PORTS-1:0] req_valid_i,
  input logic [`MEM_NUM_PORTS-1:0] req_ready_o,
  input logic [`MEM_NUM_PORTS-1:0] rsp_valid_o
);

  logic [`MEM_NUM_PORTS-1:0] accepted;

  // Number of assertion failures so far
  int unsigned error_count;

  assign accepted = req_valid_i & req_ready_o;

  // Only one port can own the memory in a cycle
  ready_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(req_ready_o))
    else begin
      $error("more than one request port is ready in the same cycle");
      error_count++;
    end

  // The response comes back exactly one cycle later on the accepted port
  rsp_follows_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    (accepted != '0) |=> (rsp_valid_o == $past(accepted)))
    else begin
      $error("response does not follow acceptance on the same port");
      error_count++;
    end

  rsp_low_after_reset: assert property (@(posedge clk_i)
    reset_i |=> (rsp_valid_o == '0))
    else begin
      $error("response valid is high in the cycle after reset");
      error_count++;
    end

endmodule

bind mem_arbiter mem_tb_sva i_mem_tb_sva (
  .clk_i       ( clk_i       ),
  .reset_i     ( reset_i     ),
  .req_valid_i ( req_valid_i ),
  .req_ready_o ( req_ready_o ),
  .rsp_valid_o ( rsp_valid_o )
);

`default_nettype wire

//--- verilog/mem_subsystem.sv
// Shared memory subsystem top

`default_nettype none

`include "mem_settings.svh"

module mem_subsystem (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic [`MEM_NUM_PORTS-1:0]                       req_valid_i,
  output logic [`MEM_NUM_PORTS-1:0]                       req_ready_o,
  input  logic [`MEM_NUM_PORTS-1:0]                       req_write_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_ADDR_WIDTH-1:0]   req_addr_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_DATA_WIDTH-1:0]   req_wdata_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_NUM_GRANULES-1:0] req_be_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_TAG_WIDTH-1:0]    req_tag_i,
  input  mem_pkg::code_word_t                             fault_mask_i,
  output logic [`MEM_NUM_PORTS-1:0]                       rsp_valid_o,
  output logic [`MEM_DATA_WIDTH-1:0]                      rsp_rdata_o,
  output mem_pkg::tag_t                                   rsp_tag_o,
  output mem_pkg::ecc_err_t                               rsp_err_o
);
  import mem_pkg::*;

  logic                          mem_req;
  logic                          mem_we;
  logic [`MEM_ADDR_WIDTH-1:0]    mem_addr;
  logic [`MEM_DATA_WIDTH-1:0]    mem_wdata;
  logic [`MEM_NUM_GRANULES-1:0]  mem_be;
  tag_t                          mem_tag;

  mem_arbiter i_mem_arbiter (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_be_i    ( req_be_i    ),
    .req_tag_i   ( req_tag_i   ),
    .rsp_valid_o ( rsp_valid_o ),
    .mem_req_o   ( mem_req     ),
    .mem_we_o    ( mem_we      ),
    .mem_addr_o  ( mem_addr    ),
    .mem_wdata_o ( mem_wdata   ),
    .mem_be_o    ( mem_be      ),
    .mem_tag_o   ( mem_tag     )
  );

  // Read data, tag and error flags are shared by all ports and qualified
  // by the per-port response valid
  ecc_sram i_ecc_sram (
    .clk_i        ( clk_i        ),
    .req_i        ( mem_req      ),
    .we_i         ( mem_we       ),
    .addr_i       ( mem_addr     ),
    .be_i         ( mem_be       ),
    .wdata_i      ( mem_wdata    ),
    .wtag_i       ( mem_tag      ),
    .fault_mask_i ( fault_mask_i ),
    .rdata_o      ( rsp_rdata_o  ),
    .rtag_o       ( rsp_tag_o    ),
    .err_o        ( rsp_err_o    )
  );

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
// Round-robin request arbiter

`default_nettype none

`include "mem_settings.svh"

module mem_arbiter (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic [`MEM_NUM_PORTS-1:0]                       req_valid_i,
  output logic [`MEM_NUM_PORTS-1:0]                       req_ready_o,
  input  logic [`MEM_NUM_PORTS-1:0]                       req_write_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_ADDR_WIDTH-1:0]   req_addr_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_DATA_WIDTH-1:0]   req_wdata_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_NUM_GRANULES-1:0] req_be_i,
  input  logic [`MEM_NUM_PORTS-1:0][`MEM_TAG_WIDTH-1:0]    req_tag_i,
  output logic [`MEM_NUM_PORTS-1:0]                       rsp_valid_o,
  output logic                                            mem_req_o,
  output logic                                            mem_we_o,
  output logic [`MEM_ADDR_WIDTH-1:0]                      mem_addr_o,
  output logic [`MEM_DATA_WIDTH-1:0]                      mem_wdata_o,
  output logic [`MEM_NUM_GRANULES-1:0]                    mem_be_o,
  output logic [`MEM_TAG_WIDTH-1:0]                       mem_tag_o
);

  localparam int NP    = `MEM_NUM_PORTS;
  localparam int IDX_W = (NP > 1) ? $clog2(NP) : 1;

  logic [IDX_W-1:0] last_q;
  logic             rsp_pending_q;
  logic [IDX_W-1:0] gnt_idx;
  logic             gnt_found;

  // Search starts one past the last winner and wraps around
  always_comb begin : pick
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int unsigned i = 1; i <= NP; i++) begin
      cand = (last_q + i) % NP;
      if (!gnt_found && req_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand[IDX_W-1:0];
      end
    end
  end

  always_comb begin
    req_ready_o = '0;
    if (gnt_found) begin
      req_ready_o[gnt_idx] = 1'b1;
    end
  end

  // Winner's fields go straight to the memory in the same cycle
  assign mem_req_o   = gnt_found;
  assign mem_we_o    = req_write_i[gnt_idx];
  assign mem_addr_o  = req_addr_i[gnt_idx];
  assign mem_wdata_o = req_wdata_i[gnt_idx];
  assign mem_be_o    = req_be_i[gnt_idx];
  assign mem_tag_o   = req_tag_i[gnt_idx];

  // The last-granted pointer doubles as the routing index of the pending
  // response, since it always names the port accepted in the previous cycle.
  // Starting at the top index hands port 0 the first grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q        <= IDX_W'(NP - 1);
      rsp_pending_q <= 1'b0;
    end else begin
      rsp_pending_q <= gnt_found;
      if (gnt_found) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_comb begin
    rsp_valid_o = '0;
    if (rsp_pending_q) begin
      rsp_valid_o[last_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ecc_sram.sv
// ECC protected word memory

`default_nettype none

`include "mem_settings.svh"

module ecc_sram (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [`MEM_ADDR_WIDTH-1:0]    addr_i,
  input  logic [`MEM_NUM_GRANULES-1:0]  be_i,
  input  logic [`MEM_DATA_WIDTH-1:0]    wdata_i,
  input  mem_pkg::tag_t                 wtag_i,
  input  mem_pkg::code_word_t           fault_mask_i,
  output logic [`MEM_DATA_WIDTH-1:0]    rdata_o,
  output mem_pkg::tag_t                 rtag_o,
  output mem_pkg::ecc_err_t             err_o
);
  import mem_pkg::*;

  localparam int GW = `MEM_GRANULE_WIDTH;
  localparam int NG = `MEM_NUM_GRANULES;

  code_word_t            enc_code;
  code_word_t            store_code;
  code_word_t            read_code;
  ecc_err_t [NG-1:0]     gran_err;
  logic [NG-1:0]         bank_req;

  for (genvar g = 0; g < NG; g++) begin : gen_bank
    // Reads touch every bank, writes only the enabled ones
    assign bank_req[g] = req_i & (~we_i | be_i[g]);

    // Injected faults land in the stored codeword only
    assign store_code[g] = enc_code[g] ^ fault_mask_i[g];

    ecc_codec i_ecc_codec (
      .wdata_i    ( wdata_i[g*GW +: GW] ),
      .wcode_o    ( enc_code[g]         ),
      .rcode_i    ( read_code[g]        ),
      .rdata_o    ( rdata_o[g*GW +: GW] ),
      .syndrome_o (                     ),
      .err_o      ( gran_err[g]         )
    );

    mem_array #(
      .entry_t ( codeword_t )
    ) i_code_array (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[g]   ),
      .we_i    ( we_i          ),
      .addr_i  ( addr_i        ),
      .wdata_i ( store_code[g] ),
      .rdata_o ( read_code[g]  )
    );
  end

  // The tag sits beside the word without protection and follows every write
  mem_array #(
    .entry_t ( tag_t )
  ) i_tag_array (
    .clk_i   ( clk_i  ),
    .req_i   ( req_i  ),
    .we_i    ( we_i   ),
    .addr_i  ( addr_i ),
    .wdata_i ( wtag_i ),
    .rdata_o ( rtag_o )
  );

  // Any granule error is reported for the whole word
  always_comb begin
    err_o = '0;
    for (int g = 0; g < NG; g++) begin
      err_o |= gran_err[g];
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_array.sv
// Single-port storage array

`default_nettype none

`include "mem_settings.svh"

module mem_array #(
  parameter type entry_t = logic
) (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`MEM_ADDR_WIDTH-1:0] addr_i,
  input  entry_t                     wdata_i,
  output entry_t                     rdata_o
);

  entry_t mem [`MEM_NUM_WORDS];

  // A read registers the entry, so data appears one cycle after the request.
  // During a write the output keeps its previous value
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ecc_codec.sv
// SECDED granule codec

`default_nettype none

`include "mem_settings.svh"

module ecc_codec (
  input  mem_pkg::granule_t  wdata_i,
  output mem_pkg::codeword_t wcode_o,
  input  mem_pkg::codeword_t rcode_i,
  output mem_pkg::granule_t  rdata_o,
  output mem_pkg::syndrome_t syndrome_o,
  output mem_pkg::ecc_err_t  err_o
);
  import mem_pkg::*;

  localparam int CW = `MEM_CODE_WIDTH;
  localparam int HB = `MEM_PARITY_WIDTH - 1;

  codeword_t   fixed_code;
  logic [HB-1:0] ham_syn;
  logic        odd_parity;

  // Bit 0 holds the overall parity, bits 1 to CW-1 are Hamming positions.
  // Data fills every position that is not a power of two
  always_comb begin : encode
    int unsigned d;
    codeword_t   code;
    d    = 0;
    code = '0;
    for (int p = 1; p < CW; p++) begin
      if ((p & (p - 1)) != 0) begin
        code[p] = wdata_i[d];
        d++;
      end
    end
    // Check bit 2**k covers every position whose index has bit k set
    for (int k = 0; k < HB; k++) begin
      for (int p = 1; p < CW; p++) begin
        if (p[k] && (p != (1 << k))) begin
          code[1 << k] ^= code[p];
        end
      end
    end
    code[0] = ^code[CW-1:1];
    wcode_o = code;
  end

  always_comb begin : decode
    ham_syn = '0;
    for (int k = 0; k < HB; k++) begin
      for (int p = 1; p < CW; p++) begin
        if (p[k]) begin
          ham_syn[k] ^= rcode_i[p];
        end
      end
    end
    odd_parity = ^rcode_i;
    fixed_code = rcode_i;
    err_o      = '0;
    if (odd_parity) begin
      // A zero syndrome here means only the parity bit itself flipped
      if (ham_syn == '0) begin
        err_o[ERR_CORR] = 1'b1;
      end else if (ham_syn < CW) begin
        fixed_code[ham_syn] = ~rcode_i[ham_syn];
        err_o[ERR_CORR]     = 1'b1;
      end else begin
        // Points outside the codeword, so more than one bit is bad
        err_o[ERR_UNCORR] = 1'b1;
      end
    end else if (ham_syn != '0) begin
      err_o[ERR_UNCORR] = 1'b1;
    end
  end

  // Pull the data bits back out of the corrected codeword
  always_comb begin : extract
    int unsigned d;
    d       = 0;
    rdata_o = '0;
    for (int p = 1; p < CW; p++) begin
      if ((p & (p - 1)) != 0) begin
        rdata_o[d] = fixed_code[p];
        d++;
      end
    end
  end

  assign syndrome_o = {odd_parity, ham_syn};

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
// Memory subsystem types

`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

  // One data granule and its SECDED codeword
  typedef logic [`MEM_GRANULE_WIDTH-1:0] granule_t;
  typedef logic [`MEM_CODE_WIDTH-1:0]    codeword_t;

  // A stored memory entry holds one codeword per granule
  typedef codeword_t [`MEM_NUM_GRANULES-1:0] code_word_t;

  // Upper bit is the overall parity check, lower bits the Hamming syndrome
  typedef logic [`MEM_PARITY_WIDTH-1:0] syndrome_t;

  typedef logic [`MEM_TAG_WIDTH-1:0] tag_t;

  typedef logic [1:0] ecc_err_t;

  // Bit positions inside ecc_err_t
  localparam int unsigned ERR_CORR   = 0;
  localparam int unsigned ERR_UNCORR = 1;

endpackage

`default_nettype wire

//--- verilog/mem_settings.svh
// Memory subsystem settings

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Word and ECC granule geometry
`define MEM_DATA_WIDTH    32
`define MEM_GRANULE_WIDTH 16
`define MEM_NUM_GRANULES  2

// Storage depth and address width
`define MEM_NUM_WORDS  256
`define MEM_ADDR_WIDTH 8

`define MEM_TAG_WIDTH 4
`define MEM_NUM_PORTS 2

// Five Hamming check bits and one overall parity bit per granule
`define MEM_PARITY_WIDTH 6
`define MEM_CODE_WIDTH   22

`endif
